//--- design/stream_pkg.sv
// stream package: AXI-Stream beat layout and realign FSM states for the rx header path
package stream_pkg;

    // beat geometry of the Ethernet side stream
    localparam int data_width = 512;
    localparam int keep_width = data_width / 8;

    // sideband widths as seen at the rx interface
    localparam int id_width   = 1;
    localparam int dest_width = 8;
    localparam int user_width = 96;

    // one AXI-Stream beat, handshake kept outside
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [keep_width-1:0] keep;
        logic                  last;
        logic [id_width-1:0]   id;
        logic [dest_width-1:0] dest;
        logic [user_width-1:0] user;
    } axis_beat_t;

    // beat as passed from capture to realign
    typedef struct packed {
        axis_beat_t beat;
        // first beat of a packet
        logic       sop;
    } in_beat_t;

    // realign FSM
    // empty: nothing held
    // hold:  one beat held, waiting for its successor
    // tail:  last beat held, its upper bytes still to go out
    typedef enum logic [1:0] {
        empty = 2'd0,
        hold  = 2'd1,
        tail  = 2'd2
    } realign_state_e;

endpackage

//--- design/hdr_pkg.sv
// header package: RoCE header layout, queue-pair field, APB types and debug register map
package hdr_pkg;

    // header occupies the low bytes of the first beat
    localparam int hdr_bytes = 62;
    localparam int hdr_width = hdr_bytes * 8;

    // destination queue pair, byte 46 of the header
    localparam int qpn_offset = 46 * 8;
    localparam int qpn_width  = 24;

    // APB port of the debug block
    localparam int apb_addr_width = 16;
    localparam int apb_data_width = 32;
    localparam int hdr_word_count = (hdr_width + apb_data_width - 1) / apb_data_width;

    // fixed identification word at the id register
    localparam logic [apb_data_width-1:0] reg_id_value = 32'h20231214;

    // fields captured from the first beat of a packet
    typedef struct packed {
        logic [hdr_width-1:0]             header;
        logic [stream_pkg::keep_width-1:0] keep;
        logic [qpn_width-1:0]             qpn;
    } hdr_info_t;

    typedef struct packed {
        logic [apb_addr_width-1:0] paddr;
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [apb_data_width-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [apb_data_width-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    // byte offsets of the read-only registers
    typedef enum logic [apb_addr_width-1:0] {
        hdr_word_0  = 16'h0000, hdr_word_1  = 16'h0004,
        hdr_word_2  = 16'h0008, hdr_word_3  = 16'h000c,
        hdr_word_4  = 16'h0010, hdr_word_5  = 16'h0014,
        hdr_word_6  = 16'h0018, hdr_word_7  = 16'h001c,
        hdr_word_8  = 16'h0020, hdr_word_9  = 16'h0024,
        hdr_word_10 = 16'h0028, hdr_word_11 = 16'h002c,
        hdr_word_12 = 16'h0030, hdr_word_13 = 16'h0034,
        hdr_word_14 = 16'h0038, hdr_word_15 = 16'h003c,
        keep_lo     = 16'h0040,
        keep_hi     = 16'h0044,
        qpn         = 16'h0048,
        id          = 16'h004c
    } reg_addr_e;

endpackage

//--- design/rx_hdr_capture.sv
// rx header capture: marks packet start and latches header, keep and destination queue pair
`timescale 1ns/100ps

module rx_hdr_capture
    import stream_pkg::*, hdr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // rx stream from the MAC side
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    input  logic       s_ready,

    // same stream tagged with start of packet
    output in_beat_t   cap_beat,
    output logic       cap_valid,

    // fields of the most recent packet header
    output hdr_info_t  hdr_info
);

    logic in_pkt;
    logic accept;
    logic sop;

    assign accept = s_valid && s_ready;

    // outside a packet the next beat is always a first beat
    assign sop = !in_pkt;

    assign cap_beat.beat = s_beat;
    assign cap_beat.sop  = sop;
    assign cap_valid     = s_valid;

    // packet tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt <= 1'b0;
        end else if (accept) begin
            in_pkt <= !s_beat.last;
        end
    end

    // header latch, updated once per packet
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_info <= '0;
        end else if (accept && sop) begin
            hdr_info.header <= s_beat.data[hdr_width-1:0];
            hdr_info.keep   <= s_beat.keep;
            // queue pair number straight from the raw beat
            hdr_info.qpn    <= s_beat.data[qpn_offset +: qpn_width];
        end
    end

endmodule

//--- design/rx_realign.sv
// rx realign: strips the 62 byte header by joining each held beat with the next one
`timescale 1ns/100ps

module rx_realign
    import stream_pkg::*, hdr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // tagged input beats from capture
    input  in_beat_t             cap_beat,
    input  logic                 cap_valid,
    output logic                 s_ready,

    // queue pair of the packet in flight
    input  logic [qpn_width-1:0] qpn,

    // header-stripped output stream
    output axis_beat_t           m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);

    realign_state_e state;
    realign_state_e state_next;

    // one beat of storage, its upper bytes go out with the next beat
    axis_beat_t held;

    // held low through reset so no beat is taken early
    logic run;

    logic in_take;
    logic out_take;
    logic load;

    assign in_take  = cap_valid && s_ready;
    assign out_take = m_valid && m_ready;

    // in empty only a first beat may start a packet, strays are dropped
    assign load = in_take && (state != empty || cap_beat.sop);

    // handshake per state
    always_comb begin
        case (state)
            empty: begin
                s_ready = run;
                m_valid = 1'b0;
            end
            hold: begin
                // one beat in, one beat out
                s_ready = m_ready;
                m_valid = cap_valid;
            end
            tail: begin
                s_ready = 1'b0;
                m_valid = 1'b1;
            end
            default: begin
                s_ready = 1'b0;
                m_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            empty: begin
                if (in_take && cap_beat.sop) begin
                    state_next = cap_beat.beat.last ? tail : hold;
                end
            end
            hold: begin
                if (in_take && cap_beat.beat.last) begin
                    state_next = tail;
                end
            end
            tail: begin
                if (out_take) begin
                    state_next = empty;
                end
            end
            default: state_next = empty;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= empty;
            run   <= 1'b0;
        end else begin
            state <= state_next;
            run   <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held <= cap_beat.beat;
        end
    end

    // output beat, sideband follows the held beat
    always_comb begin
        m_beat = held;
        m_beat.user[user_width-1 -: qpn_width] = qpn;
        if (state == tail) begin
            // only the top bytes of the last beat remain
            m_beat.data = {{hdr_width{1'b0}}, held.data[data_width-1:hdr_width]};
            m_beat.keep = held.keep >> hdr_bytes;
            m_beat.last = 1'b1;
        end else begin
            m_beat.data = {cap_beat.beat.data[hdr_width-1:0], held.data[data_width-1:hdr_width]};
            m_beat.keep = '1;
            m_beat.last = 1'b0;
        end
    end

endmodule

//--- design/hdr_regs_apb.sv
// header debug registers: read-only APB view of the last captured rx header
`timescale 1ns/100ps

module hdr_regs_apb
    import hdr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,

    // fields from the capture block
    input  hdr_info_t hdr_info
);

    // host side copy, keeps the wide read mux off the capture path
    hdr_info_t shadow;

    logic [hdr_word_count*apb_data_width-1:0] hdr_padded;
    logic [apb_data_width-1:0]                rd_data;
    logic                                     access;

    always_ff @(posedge clk) begin
        if (rst) begin
            shadow <= '0;
        end else begin
            shadow <= hdr_info;
        end
    end

    // last word carries only the upper 16 header bits
    assign hdr_padded = {{(hdr_word_count * apb_data_width - hdr_width){1'b0}}, shadow.header};

    always_comb begin
        case (apb_req.paddr)
            hdr_word_0, hdr_word_1, hdr_word_2, hdr_word_3,
            hdr_word_4, hdr_word_5, hdr_word_6, hdr_word_7,
            hdr_word_8, hdr_word_9, hdr_word_10, hdr_word_11,
            hdr_word_12, hdr_word_13, hdr_word_14, hdr_word_15: begin
                rd_data = hdr_padded[apb_req.paddr[5:2] * apb_data_width +: apb_data_width];
            end
            keep_lo: rd_data = shadow.keep[apb_data_width-1:0];
            keep_hi: rd_data = shadow.keep[2*apb_data_width-1:apb_data_width];
            qpn:     rd_data = {{(apb_data_width - qpn_width){1'b0}}, shadow.qpn};
            id:      rd_data = reg_id_value;
            // unmapped reads as zero
            default: rd_data = '0;
        endcase
    end

    assign access = apb_req.psel && apb_req.penable;

    // no wait states
    assign apb_rsp.pready = 1'b1;

    // read-only block, every write is refused
    assign apb_rsp.pslverr = access && apb_req.pwrite;
    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;

endmodule

//--- design/rx_hdr_proc_top.sv
// rx header processor top: header capture, stream realign and APB debug registers
`timescale 1ns/100ps

module rx_hdr_proc_top
    import stream_pkg::*, hdr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // rx stream in
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,

    // header-stripped stream out
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready,

    // host register port
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp
);

    in_beat_t  cap_beat;
    logic      cap_valid;
    hdr_info_t hdr_info;

    rx_hdr_capture rx_hdr_capture_i (
        .clk       (clk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .cap_beat  (cap_beat),
        .cap_valid (cap_valid),
        .hdr_info  (hdr_info)
    );

    // ready comes back from realign for both the outside and capture
    rx_realign rx_realign_i (
        .clk       (clk),
        .rst       (rst),
        .cap_beat  (cap_beat),
        .cap_valid (cap_valid),
        .s_ready   (s_ready),
        .qpn       (hdr_info.qpn),
        .m_beat    (m_beat),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

    hdr_regs_apb hdr_regs_apb_i (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .hdr_info (hdr_info)
    );

endmodule

//--- verif/tb_rx_hdr_proc.sv
// testbench for the rx header processor with random packets, a stream model and APB register checks
`timescale 1ns/100ps

module tb_rx_hdr_proc
    import stream_pkg::*, hdr_pkg::*;
;

    localparam int wait_limit  = 1000;
    localparam int num_packets = 40;

    logic       clk;
    logic       rst;
    axis_beat_t s_beat;
    logic       s_valid;
    logic       s_ready;
    axis_beat_t m_beat;
    logic       m_valid;
    logic       m_ready;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;

    logic [31:0] lfsr_state;
    axis_beat_t  exp_q[$];
    axis_beat_t  exp_beat;
    logic [23:0] last_qpn;
    logic [31:0] last_word0;
    int          errors;
    int          timeouts;
    int          beats_checked;
    int          packets;
    int          apb_reads;

    rx_hdr_proc_top rx_hdr_proc_top_i (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic int rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // step to the next drive point and redraw m_ready, low about one cycle in four
    task automatic tick();
        @(posedge clk);
        #1;
        m_ready = (rand_bits(2) != 0);
    endtask

    task automatic make_beat(output axis_beat_t b);
        int i;
        b = '0;
        for (i = 0; i < data_width; i++) begin
            b.data[i] = lfsr_bit();
        end
        b.id[0] = lfsr_bit();
        for (i = 0; i < dest_width; i++) begin
            b.dest[i] = lfsr_bit();
        end
        for (i = 0; i < user_width; i++) begin
            b.user[i] = lfsr_bit();
        end
    endtask

    task automatic send_beat(input axis_beat_t b);
        int gap;
        int cnt;
        int i;
        // occasional idle cycles before the beat
        if (rand_bits(2) == 0) begin
            gap = rand_bits(2);
            for (i = 0; i <= gap; i++) begin
                tick();
            end
        end
        s_beat  = b;
        s_valid = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!s_ready && cnt < wait_limit) begin
            tick();
            @(negedge clk);
            cnt++;
        end
        if (!s_ready) begin
            $display("input beat was not accepted within %0d cycles", wait_limit);
            timeouts++;
        end
        tick();
        s_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < wait_limit) begin
            tick();
            cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("output stream stopped with %0d beats still expected", exp_q.size());
            timeouts++;
        end
    endtask

    task automatic apb_access(input logic [15:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int cnt;
        tick();
        apb_req.paddr   = addr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        tick();
        apb_req.penable = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!apb_rsp.pready && cnt < wait_limit) begin
            tick();
            @(negedge clk);
            cnt++;
        end
        if (!apb_rsp.pready) begin
            $display("APB access to address %h never completed", addr);
            timeouts++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        tick();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, input logic [31:0] expected,
                            input string name);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b0, 32'h0, rdata, err);
        apb_reads++;
        if (rdata !== expected) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, rdata);
            errors++;
        end
        if (err !== 1'b0) begin
            $display("[ERROR] %0t pslverr on %s expected 0 actual %b", $time, name, err);
            errors++;
        end
    endtask

    // registers hold the header of the packet just sent
    task automatic check_regs(input axis_beat_t b0, input logic [23:0] qpn_val);
        logic [31:0] word;
        int          k;
        for (k = 0; k < 16 && timeouts == 0; k++) begin
            word = (k == 15) ? {16'h0, b0.data[495:480]} : b0.data[32*k +: 32];
            read_reg(16'(k * 4), word, $sformatf("hdr_word_%0d", k));
        end
        read_reg(16'h0040, b0.keep[31:0], "keep_lo");
        read_reg(16'h0044, b0.keep[63:32], "keep_hi");
        read_reg(16'h0048, {8'h0, qpn_val}, "qpn");
        read_reg(16'h004c, 32'h2023_1214, "id");
    endtask

    task automatic run_packet();
        axis_beat_t  pkt [5];
        axis_beat_t  e;
        logic [23:0] qpn_val;
        int          n;
        int          j;
        n = 2 + rand_bits(2);
        for (j = 0; j < n; j++) begin
            make_beat(pkt[j]);
            pkt[j].keep = '1;
            pkt[j].last = (j == n - 1);
        end
        // last beat carries 63 or 64 bytes
        if (lfsr_bit()) begin
            pkt[n-1].keep = {1'b0, {63{1'b1}}};
        end
        qpn_val = pkt[0].data[391:368];
        for (j = 0; j < n - 1; j++) begin
            e = pkt[j];
            e.data = {pkt[j+1].data[495:0], pkt[j].data[511:496]};
            e.keep = '1;
            e.last = 1'b0;
            e.user[95:72] = qpn_val;
            exp_q.push_back(e);
        end
        e = pkt[n-1];
        e.data = {496'h0, pkt[n-1].data[511:496]};
        e.keep = pkt[n-1].keep >> 62;
        e.last = 1'b1;
        e.user[95:72] = qpn_val;
        exp_q.push_back(e);
        for (j = 0; j < n && timeouts == 0; j++) begin
            send_beat(pkt[j]);
        end
        if (timeouts == 0) begin
            wait_drain();
        end
        packets++;
        last_qpn   = qpn_val;
        last_word0 = pkt[0].data[31:0];
        if (timeouts == 0) begin
            check_regs(pkt[0], qpn_val);
        end
    endtask

    task automatic check_apb_errors();
        logic [31:0] rdata;
        logic        err;
        apb_access(16'h0048, 1'b1, 32'h00ab_cdef, rdata, err);
        if (err !== 1'b1) begin
            $display("[ERROR] %0t pslverr on write expected 1 actual %b", $time, err);
            errors++;
        end
        apb_access(16'h0000, 1'b1, 32'hffff_ffff, rdata, err);
        if (err !== 1'b1) begin
            $display("[ERROR] %0t pslverr on write expected 1 actual %b", $time, err);
            errors++;
        end
        read_reg(16'h0048, {8'h0, last_qpn}, "qpn after write");
        read_reg(16'h0000, last_word0, "hdr_word_0 after write");
        read_reg(16'h0080, 32'h0, "unmapped 0x80");
    endtask

    // output monitor sampling mid-cycle
    always @(negedge clk) begin
        if (!rst && m_valid) begin
            if (exp_q.size() == 0) begin
                $display("output beat appeared at %0t with no beat expected", $time);
                errors++;
            end else if (m_ready) begin
                exp_beat = exp_q.pop_front();
                beats_checked++;
                if (m_beat.data !== exp_beat.data) begin
                    $display("[ERROR] %0t m_beat.data expected %h actual %h",
                             $time, exp_beat.data, m_beat.data);
                    errors++;
                end
                if (m_beat.keep !== exp_beat.keep) begin
                    $display("[ERROR] %0t m_beat.keep expected %h actual %h",
                             $time, exp_beat.keep, m_beat.keep);
                    errors++;
                end
                if (m_beat.last !== exp_beat.last) begin
                    $display("[ERROR] %0t m_beat.last expected %b actual %b",
                             $time, exp_beat.last, m_beat.last);
                    errors++;
                end
                if (m_beat.id !== exp_beat.id || m_beat.dest !== exp_beat.dest) begin
                    $display("[ERROR] %0t m_beat.id/dest expected %h/%h actual %h/%h",
                             $time, exp_beat.id, exp_beat.dest, m_beat.id, m_beat.dest);
                    errors++;
                end
                if (m_beat.user !== exp_beat.user) begin
                    $display("[ERROR] %0t m_beat.user expected %h actual %h",
                             $time, exp_beat.user, m_beat.user);
                    errors++;
                end
            end
        end
    end

    initial begin
        int p;
        lfsr_state = 32'hd9d0;
        errors = 0;
        timeouts = 0;
        beats_checked = 0;
        packets = 0;
        apb_reads = 0;
        rst = 1'b1;
        s_beat = '0;
        s_valid = 1'b0;
        m_ready = 1'b0;
        apb_req = '0;
        // both stream handshakes stay low while reset is held
        tick();
        repeat (9) begin
            @(negedge clk);
            if (s_ready !== 1'b0) begin
                $display("[ERROR] %0t s_ready in reset expected 0 actual %b", $time, s_ready);
                errors++;
            end
            if (m_valid !== 1'b0) begin
                $display("[ERROR] %0t m_valid in reset expected 0 actual %b", $time, m_valid);
                errors++;
            end
            tick();
        end
        rst = 1'b0;
        tick();
        @(negedge clk);
        if (m_valid !== 1'b0) begin
            $display("[ERROR] %0t m_valid expected 0 actual %b", $time, m_valid);
            errors++;
        end
        read_reg(16'h0048, 32'h0, "qpn after reset");
        read_reg(16'h0040, 32'h0, "keep_lo after reset");
        read_reg(16'h0044, 32'h0, "keep_hi after reset");
        for (p = 0; p < num_packets && timeouts == 0; p++) begin
            run_packet();
        end
        if (timeouts == 0) begin
            check_apb_errors();
        end
        $display("errors %0d, timeouts %0d, beats checked %0d, packets %0d, register reads %0d",
                 errors, timeouts, beats_checked, packets, apb_reads);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- build.f
design/stream_pkg.sv
design/hdr_pkg.sv
design/rx_hdr_capture.sv
design/rx_realign.sv
design/hdr_regs_apb.sv
design/rx_hdr_proc_top.sv
verif/tb_rx_hdr_proc.sv

//--- run.sh
#!/bin/sh
# compile and run the rx header processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir
rm -f "$log"

verilator --binary --timing --top-module tb_rx_hdr_proc -f build.f -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$log"; then
    exit 1
fi

exit 0
